// File: aq_consts.svh
// Bus glue constants for I/O port addresses, page decode, sync depth and register bit positions
`ifndef AQ_CONSTS_SVH
`define AQ_CONSTS_SVH

////////////////////////////////
// I/O port addresses
////////////////////////////////
`define AQ_IO_DAC       8'hEC   // Audio DAC
`define AQ_IO_BANK0     8'hF0
`define AQ_IO_BANK1     8'hF1
`define AQ_IO_BANK2     8'hF2
`define AQ_IO_BANK3     8'hF3
`define AQ_IO_ESPCTRL   8'hF4   // ESP UART status / control
`define AQ_IO_ESPDATA   8'hF5   // ESP UART data
`define AQ_IO_SYSCTRL   8'hFB
`define AQ_IO_CASS      8'hFC
`define AQ_IO_CPM       8'hFD   // CP/M remap on write and 0 on read
`define AQ_IO_PRINTER   8'hFE
`define AQ_IO_KEYB      8'hFF

////////////////////////////////
// Memory map
////////////////////////////////
// Cartridge occupies pages 16-19
`define AQ_PAGE_CART_HI 4'b0100

// Input synchronizer depth
`define AQ_SYNC_STAGES  3

////////////////////////////////
// Sysctrl ($FB) bits
////////////////////////////////
`define AQ_SYSCTRL_DIS_REGS 0
`define AQ_SYSCTRL_TURBO    2
`define AQ_SYSCTRL_UNL      6
`define AQ_SYSCTRL_UNL_WE   7   // Must be set to change the unlimited bit

////////////////////////////////
// ESP control ($F4) write bits
////////////////////////////////
`define AQ_ESP_CLR_FERR 3
`define AQ_ESP_CLR_OVF  4
`define AQ_ESP_BREAK    7       // Queue a break on the tx side

`endif

// File: aq_pkg.sv
// Shared bus, bank, read-response and audio types of the system bus glue
package aq_pkg;

    // Plain vectors with a meaning
    typedef logic [15:0] addr_t;    // CPU bus address
    typedef logic  [7:0] byte_t;    // CPU bus data
    typedef logic  [5:0] page_t;    // One of 64 physical 16 KB pages
    typedef logic [15:0] sample_t;  // Offset binary audio

    // One bank register laid out like the $F0-$F3 byte
    typedef struct packed {
        logic  ro;          // Bit 7 blocks RAM writes
        logic  overlay;     // Bit 6 opens the system RAM window at $3800
        page_t page;        // Bits 5..0
    } bank_reg_t;

    // Decoded bus cycle with active high flags
    typedef struct packed {
        addr_t addr;
        byte_t wrdata;
        logic  mreq;
        logic  iorq;
        logic  rd;
        logic  wr;
        logic  wr_stb;      // Write qualified by the bus strobe
    } bus_cycle_t;

    // Read data offered by one decoder
    typedef struct packed {
        logic  hit;
        byte_t data;
    } rd_resp_t;

endpackage

// File: aq_bank_decode.sv
// Bank registers and memory-space decoding into page, chip selects and RAM write enable
`timescale 1ns/1ns
`include "aq_consts.svh"

module aq_bank_decode (
    input  logic               clk,
    input  logic               reset,
    input  aq_pkg::bus_cycle_t bus,
    input  logic               dis_regs,
    output logic [4:0]         ebus_ba,
    output logic               ram_ce_n,
    output logic               cart_ce_n,
    output logic               ram_we_n,
    output aq_pkg::rd_resp_t   rd_resp
);
    import aq_pkg::*;

    bank_reg_t q_bank [4];      // $F0-$F3
    bank_reg_t cur_bank;        // Bank of the current memory window

    logic sel_io_bank;
    logic bank_wr;
    logic sel_ram;
    logic sel_cart;
    logic sysram_win;

    ////////////////////////////////
    // Bank register access
    ////////////////////////////////
    assign sel_io_bank = bus.iorq && !dis_regs &&
                         (bus.addr[7:0] == `AQ_IO_BANK0 ||
                          bus.addr[7:0] == `AQ_IO_BANK1 ||
                          bus.addr[7:0] == `AQ_IO_BANK2 ||
                          bus.addr[7:0] == `AQ_IO_BANK3);

    assign bank_wr = sel_io_bank && bus.wr_stb;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                q_bank[i] <= '0;
            end
        end else if (bank_wr) begin
            q_bank[bus.addr[1:0]] <= bank_reg_t'(bus.wrdata); // Low bits pick the bank
        end
    end

    assign rd_resp.hit  = sel_io_bank;
    assign rd_resp.data = byte_t'(q_bank[bus.addr[1:0]]);

    ////////////////////////////////
    // Memory decoding
    ////////////////////////////////
    // Each 16 KB window has its own bank register
    assign cur_bank = q_bank[bus.addr[15:14]];

    assign ebus_ba = cur_bank.page[4:0];

    assign sel_cart = bus.mreq && cur_bank.page[5:2] == `AQ_PAGE_CART_HI;  // Pages 16-19
    assign sel_ram  = bus.mreq && cur_bank.page[5];                         // Pages 32-63

    // Top 2 KB of an overlay window stays writable in read-only banks
    assign sysram_win = cur_bank.overlay && bus.addr[13:11] == 3'b111;

    assign ram_ce_n  = !sel_ram;
    assign cart_ce_n = !sel_cart;
    assign ram_we_n  = !(sel_ram && bus.wr && (!cur_bank.ro || sysram_win));

endmodule

// File: aq_io_regs.sv
// I/O registers for system control, audio DAC, ESP UART, cassette, printer and keyboard
`timescale 1ns/1ns
`include "aq_consts.svh"

module aq_io_regs (
    input  logic               clk,
    input  logic               reset,
    input  aq_pkg::bus_cycle_t bus,
    input  logic [63:0]        keys,
    input  logic               cassette_in,
    input  logic               printer_in,
    input  logic               esp_tx_fifo_full,
    input  logic               esp_rx_empty,
    input  logic               esp_rx_fifo_overflow,
    input  logic               esp_rx_framing_error,
    input  logic [8:0]         esp_rx_data,    // Bit 8 flags a received break
    output logic [8:0]         esp_tx_data,    // Bit 8 requests a break
    output logic               esp_tx_wr,
    output logic               esp_rx_rd,
    output logic               cassette_out,
    output logic               printer_out,
    output logic               cpm_remap,
    output logic               turbo,
    output logic               turbo_unlimited,
    output logic               dis_regs,
    output aq_pkg::sample_t    audio_out,
    output aq_pkg::rd_resp_t   rd_resp
);
    import aq_pkg::*;

    byte_t q_dac;
    logic  q_turbo, q_unl, q_dis_regs;
    logic  q_cass_out, q_prn_out, q_cpm;
    logic  q_ovf, q_ferr;
    logic  [`AQ_SYNC_STAGES-1:0] q_cass_sync;
    logic  [`AQ_SYNC_STAGES-1:0] q_prn_sync;

    logic  sel_dac, sel_espctrl, sel_espdata;
    logic  sel_sysctrl, sel_cass, sel_cpm, sel_prn, sel_keyb;
    byte_t espctrl_data;
    byte_t keyb_data;
    logic  [13:0] mix;

    ////////////////////////////////
    // Port decoding
    ////////////////////////////////
    assign sel_dac     = bus.iorq && !q_dis_regs && bus.addr[7:0] == `AQ_IO_DAC;
    assign sel_espctrl = bus.iorq && !q_dis_regs && bus.addr[7:0] == `AQ_IO_ESPCTRL;
    assign sel_espdata = bus.iorq && !q_dis_regs && bus.addr[7:0] == `AQ_IO_ESPDATA;
    assign sel_sysctrl = bus.iorq && bus.addr[7:0] == `AQ_IO_SYSCTRL;
    assign sel_cass    = bus.iorq && bus.addr[7:0] == `AQ_IO_CASS;
    assign sel_cpm     = bus.iorq && bus.addr[7:0] == `AQ_IO_CPM;
    assign sel_prn     = bus.iorq && bus.addr[7:0] == `AQ_IO_PRINTER;
    assign sel_keyb    = bus.iorq && bus.addr[7:0] == `AQ_IO_KEYB;

    ////////////////////////////////
    // Registers and synchronizers
    ////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_dac       <= '0;
            q_turbo     <= 1'b0;
            q_unl       <= 1'b0;
            q_dis_regs  <= 1'b0;
            q_cass_out  <= 1'b0;
            q_prn_out   <= 1'b0;
            q_cpm       <= 1'b0;
            q_ovf       <= 1'b0;
            q_ferr      <= 1'b0;
            q_cass_sync <= '0;
            q_prn_sync  <= '0;
        end else begin
            q_cass_sync <= {q_cass_sync[`AQ_SYNC_STAGES-2:0], cassette_in};
            q_prn_sync  <= {q_prn_sync[`AQ_SYNC_STAGES-2:0], printer_in};

            if (bus.wr_stb) begin
                if (sel_dac)  q_dac      <= bus.wrdata;
                if (sel_cass) q_cass_out <= bus.wrdata[0];
                if (sel_cpm)  q_cpm      <= bus.wrdata[0];
                if (sel_prn)  q_prn_out  <= bus.wrdata[0];
                if (sel_sysctrl) begin
                    if (bus.wrdata[`AQ_SYSCTRL_UNL_WE])
                        q_unl <= bus.wrdata[`AQ_SYSCTRL_UNL];
                    q_turbo    <= bus.wrdata[`AQ_SYSCTRL_TURBO];
                    q_dis_regs <= bus.wrdata[`AQ_SYSCTRL_DIS_REGS];
                end
                if (sel_espctrl) begin
                    q_ovf  <= q_ovf & ~bus.wrdata[`AQ_ESP_CLR_OVF];
                    q_ferr <= q_ferr & ~bus.wrdata[`AQ_ESP_CLR_FERR];
                end
            end

            // Error pulses override a clear in the same cycle
            if (esp_rx_fifo_overflow) q_ovf  <= 1'b1;
            if (esp_rx_framing_error) q_ferr <= 1'b1;
        end
    end

    assign cassette_out    = q_cass_out;
    assign printer_out     = q_prn_out;
    assign cpm_remap       = q_cpm;
    assign turbo           = q_turbo;
    assign turbo_unlimited = q_unl;
    assign dis_regs        = q_dis_regs;

    ////////////////////////////////
    // ESP UART
    ////////////////////////////////
    assign esp_tx_data = sel_espctrl ? 9'h100 : {1'b0, bus.wrdata};
    assign esp_tx_wr   = bus.wr_stb &&
                         (sel_espdata || (sel_espctrl && bus.wrdata[`AQ_ESP_BREAK]));
    assign esp_rx_rd   = bus.rd && sel_espdata;  // Pops one entry per read cycle

    assign espctrl_data = {3'b0, q_ovf, q_ferr, esp_rx_data[8], esp_tx_fifo_full, !esp_rx_empty};

    // Keyboard rows take part when their address bit is low
    always_comb begin
        keyb_data = 8'hFF;
        for (int n = 0; n < 8; n++) begin
            if (!bus.addr[8+n])
                keyb_data = keyb_data & keys[8*n +: 8];
        end
    end

    ////////////////////////////////
    // Audio mix
    ////////////////////////////////
    assign mix = {2'b0, q_dac, 4'b0} + (q_cass_out ? 14'd1023 : 14'd0);  // DAC plus beep

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            audio_out <= '0;
        else
            audio_out <= {~mix[13], mix[12:0], 2'b0};
    end

    ////////////////////////////////
    // Read data
    ////////////////////////////////
    always_comb begin
        rd_resp = '0;
        if (sel_dac)     rd_resp = '{hit: 1'b1, data: q_dac};
        if (sel_espctrl) rd_resp = '{hit: 1'b1, data: espctrl_data};
        if (sel_espdata) rd_resp = '{hit: 1'b1, data: esp_rx_data[7:0]};
        if (sel_sysctrl) rd_resp = '{hit: 1'b1, data: {1'b0, q_unl, 3'b0, q_turbo, 1'b0, q_dis_regs}};
        if (sel_cass)    rd_resp = '{hit: 1'b1, data: {7'b0, !q_cass_sync[`AQ_SYNC_STAGES-1]}};
        if (sel_cpm)     rd_resp = '{hit: 1'b1, data: 8'h00};    // No vsync here
        if (sel_prn)     rd_resp = '{hit: 1'b1, data: {7'b0, q_prn_sync[`AQ_SYNC_STAGES-1]}};
        if (sel_keyb)    rd_resp = '{hit: 1'b1, data: keyb_data};
    end

endmodule

// File: aq_read_mux.sv
// Read multiplexer combining the decoder responses into bus data and output enable
`timescale 1ns/1ns

module aq_read_mux (
    input  aq_pkg::bus_cycle_t bus,
    input  aq_pkg::rd_resp_t   bank_resp,
    input  aq_pkg::rd_resp_t   io_resp,
    output aq_pkg::byte_t      ebus_d_out,
    output logic               ebus_d_oe
);

    logic any_hit;

    assign any_hit = bank_resp.hit || io_resp.hit;

    // Decoders never hit together
    always_comb begin
        if (bank_resp.hit)
            ebus_d_out = bank_resp.data;
        else if (io_resp.hit)
            ebus_d_out = io_resp.data;
        else
            ebus_d_out = '0;    // Idle bus data
    end

    // Drive the bus only during a read of an internal register
    assign ebus_d_oe = bus.rd && any_hit;

endmodule

// File: aq_bus.sv
// Top level of the system bus glue with memory banking and I/O registers
`timescale 1ns/1ns

module aq_bus (
    input  logic            clk,
    input  logic            reset,

    // External Z80 bus
    input  logic [15:0]     ebus_a,
    input  logic [7:0]      ebus_d_in,
    output logic [7:0]      ebus_d_out,
    output logic            ebus_d_oe,
    input  logic            ebus_rd_n,
    input  logic            ebus_wr_n,
    input  logic            ebus_mreq_n,
    input  logic            ebus_iorq_n,
    input  logic            ebus_stb,
    output logic [4:0]      ebus_ba,
    output logic            ebus_ram_ce_n,      // 512 KB RAM
    output logic            ebus_cart_ce_n,
    output logic            ebus_ram_we_n,

    input  logic [63:0]     keys,

    // ESP UART
    output logic [8:0]      esp_tx_data,
    output logic            esp_tx_wr,
    input  logic            esp_tx_fifo_full,
    input  logic [8:0]      esp_rx_data,
    output logic            esp_rx_rd,
    input  logic            esp_rx_empty,
    input  logic            esp_rx_fifo_overflow,
    input  logic            esp_rx_framing_error,

    // Misc ports
    output logic            cassette_out,
    input  logic            cassette_in,
    output logic            printer_out,
    input  logic            printer_in,
    output logic            cpm_remap,
    output logic            turbo,
    output logic            turbo_unlimited,
    output aq_pkg::sample_t audio_out
);
    import aq_pkg::*;

    bus_cycle_t bus;
    rd_resp_t   bank_resp;
    rd_resp_t   io_resp;
    logic       dis_regs;

    // Active-low pins to active-high flags
    always_comb begin
        bus.addr   = ebus_a;
        bus.wrdata = ebus_d_in;
        bus.mreq   = !ebus_mreq_n;
        bus.iorq   = !ebus_iorq_n;
        bus.rd     = !ebus_rd_n;
        bus.wr     = !ebus_wr_n;
        bus.wr_stb = !ebus_wr_n && ebus_stb;
    end

    aq_bank_decode i_bank_decode (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .dis_regs  (dis_regs),
        .ebus_ba   (ebus_ba),
        .ram_ce_n  (ebus_ram_ce_n),
        .cart_ce_n (ebus_cart_ce_n),
        .ram_we_n  (ebus_ram_we_n),
        .rd_resp   (bank_resp)
    );

    aq_io_regs i_io_regs (
        .clk                  (clk),
        .reset                (reset),
        .bus                  (bus),
        .keys                 (keys),
        .cassette_in          (cassette_in),
        .printer_in           (printer_in),
        .esp_tx_fifo_full     (esp_tx_fifo_full),
        .esp_rx_empty         (esp_rx_empty),
        .esp_rx_fifo_overflow (esp_rx_fifo_overflow),
        .esp_rx_framing_error (esp_rx_framing_error),
        .esp_rx_data          (esp_rx_data),
        .esp_tx_data          (esp_tx_data),
        .esp_tx_wr            (esp_tx_wr),
        .esp_rx_rd            (esp_rx_rd),
        .cassette_out         (cassette_out),
        .printer_out          (printer_out),
        .cpm_remap            (cpm_remap),
        .turbo                (turbo),
        .turbo_unlimited      (turbo_unlimited),
        .dis_regs             (dis_regs),
        .audio_out            (audio_out),
        .rd_resp              (io_resp)
    );

    aq_read_mux i_read_mux (
        .bus        (bus),
        .bank_resp  (bank_resp),
        .io_resp    (io_resp),
        .ebus_d_out (ebus_d_out),
        .ebus_d_oe  (ebus_d_oe)
    );

endmodule

// File: tb_aq_model.svh
// Reference model of the bus glue registers, memory map and audio mix
`ifndef TB_AQ_MODEL_SVH
`define TB_AQ_MODEL_SVH

// Mirrored register state
logic [7:0] m_bank [4];
logic [7:0] m_dac;
logic       m_turbo, m_unl, m_dis;
logic       m_cass, m_prn, m_cpm;
logic       m_ovf, m_ferr;

function automatic void model_reset();
    for (int i = 0; i < 4; i++) begin
        m_bank[i] = 8'h00;
    end
    m_dac   = 8'h00;
    m_turbo = 1'b0;
    m_unl   = 1'b0;
    m_dis   = 1'b0;
    m_cass  = 1'b0;
    m_prn   = 1'b0;
    m_cpm   = 1'b0;
    m_ovf   = 1'b0;
    m_ferr  = 1'b0;
endfunction

// Strobed I/O write
function automatic void model_write(input logic [15:0] a, input logic [7:0] d);
    case (a[7:0])
        `AQ_IO_DAC:     if (!m_dis) m_dac = d;
        `AQ_IO_BANK0, `AQ_IO_BANK1, `AQ_IO_BANK2, `AQ_IO_BANK3:
            if (!m_dis) m_bank[a[1:0]] = d;
        `AQ_IO_ESPCTRL: begin
            if (!m_dis && d[`AQ_ESP_CLR_OVF]) m_ovf = 1'b0;
            if (!m_dis && d[`AQ_ESP_CLR_FERR]) m_ferr = 1'b0;
        end
        `AQ_IO_SYSCTRL: begin
            m_turbo = d[`AQ_SYSCTRL_TURBO];
            if (d[`AQ_SYSCTRL_UNL_WE]) m_unl = d[`AQ_SYSCTRL_UNL];   // Write-enable gate
            m_dis = d[`AQ_SYSCTRL_DIS_REGS];
        end
        `AQ_IO_CASS:    m_cass = d[0];
        `AQ_IO_CPM:     m_cpm = d[0];
        `AQ_IO_PRINTER: m_prn = d[0];
        default: ;
    endcase
endfunction

// AND of every row whose high address bit is low
function automatic logic [7:0] exp_keyb(input logic [7:0] hi, input logic [63:0] k);
    logic [7:0] r;
    r = 8'hFF;
    for (int n = 0; n < 8; n++) begin
        if (!hi[n]) r = r & k[8*n +: 8];
    end
    return r;
endfunction

// Expected hit and data of an I/O read with settled inputs
function automatic void exp_io_read(input logic [15:0] a, output logic hit,
                                    output logic [7:0] d);
    logic [7:0] p;
    logic       gated;
    p     = a[7:0];
    hit   = 1'b0;
    d     = 8'h00;
    gated = p == `AQ_IO_DAC || (p >= `AQ_IO_BANK0 && p <= `AQ_IO_ESPDATA);
    if (m_dis && gated) return;
    hit = 1'b1;
    case (p)
        `AQ_IO_DAC:     d = m_dac;
        `AQ_IO_BANK0, `AQ_IO_BANK1, `AQ_IO_BANK2, `AQ_IO_BANK3: d = m_bank[p[1:0]];
        `AQ_IO_ESPCTRL: d = {3'b000, m_ovf, m_ferr, esp_rx_data[8], esp_tx_fifo_full,
                             !esp_rx_empty};
        `AQ_IO_ESPDATA: d = esp_rx_data[7:0];
        `AQ_IO_SYSCTRL: begin
            d[`AQ_SYSCTRL_UNL]      = m_unl;
            d[`AQ_SYSCTRL_TURBO]    = m_turbo;
            d[`AQ_SYSCTRL_DIS_REGS] = m_dis;
        end
        `AQ_IO_CASS:    d = {7'b0, !cassette_in};   // Inverted input
        `AQ_IO_CPM:     d = 8'h00;
        `AQ_IO_PRINTER: d = {7'b0, printer_in};
        `AQ_IO_KEYB:    d = exp_keyb(a[15:8], keys);
        default:        hit = 1'b0;
    endcase
endfunction

// Packed as {ba, ram_ce_n, cart_ce_n, ram_we_n}
function automatic logic [7:0] exp_mem(input logic [15:0] a, input logic wr);
    logic [7:0] b;
    logic [5:0] pg;
    logic       ram, cart, we;
    b    = m_bank[a[15:14]];
    pg   = b[5:0];
    ram  = pg >= 6'd32;
    cart = pg >= 6'd16 && pg <= 6'd19;
    // Overlay keeps the top 2 KB of the window writable
    we   = ram && wr && (!b[7] || (b[6] && a[13:11] == 3'b111));
    return {pg[4:0], !ram, !cart, !we};
endfunction

function automatic logic [15:0] exp_audio();
    int level;
    level = m_dac * 16 + (m_cass ? 1023 : 0);
    return 16'((level + 8192) * 4);     // Offset binary around 32768
endfunction

`endif

// File: tb_aq_bus.sv
// Testbench for the bus glue with LFSR stimulus checked against a register model
`timescale 1ns/1ns
`include "aq_consts.svh"

module tb_aq_bus;

    localparam int CLK_NS = 4;
    localparam int ITERS = 48;
    // Cycles per iteration of tests 1 to 6 are 6 + 6 + 4 + 1 + 10 + 6
    localparam int ITER_CYCLES = 33;
    localparam int WATCH_NS = (2 * ITERS * ITER_CYCLES + 100) * CLK_NS;

    logic        clk, reset;
    logic [15:0] ebus_a;
    logic [7:0]  ebus_d_in, ebus_d_out;
    logic        ebus_d_oe, ebus_rd_n, ebus_wr_n, ebus_mreq_n, ebus_iorq_n, ebus_stb;
    logic [4:0]  ebus_ba;
    logic        ebus_ram_ce_n, ebus_cart_ce_n, ebus_ram_we_n;
    logic [63:0] keys;
    logic [8:0]  esp_tx_data, esp_rx_data;
    logic        esp_tx_wr, esp_tx_fifo_full, esp_rx_rd, esp_rx_empty;
    logic        esp_rx_fifo_overflow, esp_rx_framing_error;
    logic        cassette_out, cassette_in, printer_out, printer_in;
    logic        cpm_remap, turbo, turbo_unlimited;
    logic [15:0] audio_out;

    logic [31:0] lfsr;
    int          errors, tests_run, tests_clean;
    string       cur_test;

    aq_bus i_dut (.*);

    `include "tb_aq_model.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCH_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCH_NS);
        $display("tests failed");
        $finish;
    end

    //////////////////////////////
    // Random numbers and reporting
    //////////////////////////////
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rnd(input int nbits);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_error(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
        errors++;
        $display("Error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    endtask

    task automatic finish_test(input int e0);
        tests_run++;
        if (errors == e0) begin
            tests_clean++;
            $display("PASS %s", cur_test);
        end else begin
            $display("FAIL %s with %0d mismatches", cur_test, errors - e0);
        end
    endtask

    //////////////////////////////
    // Bus cycles
    //////////////////////////////
    task automatic start_cycle(input logic io, input logic wr, input logic [15:0] a,
                               input logic [7:0] d, input logic stb);
        ebus_a      = a;
        ebus_d_in   = d;
        ebus_iorq_n = !io;
        ebus_mreq_n = io;
        ebus_wr_n   = !wr;
        ebus_rd_n   = wr;
        ebus_stb    = stb;
        #1;     // Combinational outputs settle
    endtask

    task automatic end_cycle();
        @(negedge clk);
        ebus_rd_n   = 1'b1;
        ebus_wr_n   = 1'b1;
        ebus_mreq_n = 1'b1;
        ebus_iorq_n = 1'b1;
        ebus_stb    = 1'b0;
    endtask

    task automatic io_write(input logic [15:0] a, input logic [7:0] d, input logic stb);
        logic       exp_wr;
        logic [8:0] exp_txd;
        start_cycle(1'b1, 1'b1, a, d, stb);
        exp_wr  = stb && !m_dis && (a[7:0] == `AQ_IO_ESPDATA ||
                  (a[7:0] == `AQ_IO_ESPCTRL && d[`AQ_ESP_BREAK]));
        exp_txd = (a[7:0] == `AQ_IO_ESPCTRL) ? 9'h100 : {1'b0, d};   // Break request
        if (esp_tx_wr !== exp_wr) report_error("esp_tx_wr", 64'(exp_wr), 64'(esp_tx_wr));
        if (exp_wr && esp_tx_data !== exp_txd)
            report_error("esp_tx_data", 64'(exp_txd), 64'(esp_tx_data));
        end_cycle();
        if (stb) model_write(a, d);
    endtask

    task automatic check_io_read(input string what, input logic [15:0] a);
        logic       hit, rxrd;
        logic [7:0] ed;
        start_cycle(1'b1, 1'b0, a, 8'h00, 1'b0);
        exp_io_read(a, hit, ed);
        rxrd = hit && a[7:0] == `AQ_IO_ESPDATA;
        if ({ebus_d_oe, ebus_d_out} !== {hit, ed})
            report_error(what, 64'({hit, ed}), 64'({ebus_d_oe, ebus_d_out}));
        if (esp_rx_rd !== rxrd) report_error("esp_rx_rd", 64'(rxrd), 64'(esp_rx_rd));
        end_cycle();
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    task automatic test_banks();
        logic [15:0] a;
        logic [7:0]  exp8, got8;
        logic        wr;
        int          e0;
        e0 = errors;
        cur_test = "bank";
        repeat (ITERS) begin
            a = {8'(rnd(8)), 6'b111100, 2'(rnd(2))};
            io_write(a, 8'(rnd(8)), 1'b1);
            check_io_read("readback", a);
            repeat (4) begin
                a  = 16'(rnd(16));
                wr = 1'(rnd(1));
                start_cycle(1'b0, wr, a, 8'h00, 1'b1);
                exp8 = exp_mem(a, wr);
                got8 = {ebus_ba, ebus_ram_ce_n, ebus_cart_ce_n, ebus_ram_we_n};
                if (got8 !== exp8) report_error("memory decode", 64'(exp8), 64'(got8));
                end_cycle();
            end
        end
        finish_test(e0);
    endtask

    task automatic test_sysctrl();
        logic [15:0] a;
        logic [2:0]  p;
        int          e0;
        e0 = errors;
        cur_test = "sysctrl";
        repeat (ITERS) begin
            io_write({8'h00, `AQ_IO_SYSCTRL}, 8'(rnd(8)), 1'b1);
            if ({turbo, turbo_unlimited} !== {m_turbo, m_unl})
                report_error("turbo", 64'({m_turbo, m_unl}), 64'({turbo, turbo_unlimited}));
            check_io_read("readback", {8'h00, `AQ_IO_SYSCTRL});
            p = 3'(rnd(3));
            a = (p > 3'd5) ? {8'h00, `AQ_IO_DAC} : {8'h00, `AQ_IO_BANK0 + 8'(p)};
            io_write(a, 8'(rnd(8)), 1'b1);
            check_io_read("gated port", a);
            // Registers enabled again so a gated write shows up as kept data
            io_write({8'h00, `AQ_IO_SYSCTRL}, 8'h00, 1'b1);
            check_io_read("gated port kept", a);
        end
        finish_test(e0);
    endtask

    task automatic test_esp();
        logic ovf, ferr;
        int   e0;
        e0 = errors;
        cur_test = "esp";
        repeat (ITERS) begin
            esp_tx_fifo_full     = 1'(rnd(1));
            esp_rx_empty         = 1'(rnd(1));
            esp_rx_data          = 9'(rnd(9));
            ovf                  = 2'(rnd(2)) == 2'd0;
            ferr                 = 2'(rnd(2)) == 2'd0;
            esp_rx_fifo_overflow = ovf;
            esp_rx_framing_error = ferr;
            io_write({8'h00, `AQ_IO_ESPCTRL}, 8'(rnd(8)), 1'b1);
            esp_rx_fifo_overflow = 1'b0;
            esp_rx_framing_error = 1'b0;
            // Pulse beats a clear in the same cycle
            if (ovf) m_ovf = 1'b1;
            if (ferr) m_ferr = 1'b1;
            check_io_read("status", {8'h00, `AQ_IO_ESPCTRL});
            io_write({8'h00, `AQ_IO_ESPDATA}, 8'(rnd(8)), 1'b1);
            check_io_read("rx data", {8'h00, `AQ_IO_ESPDATA});
        end
        finish_test(e0);
    endtask

    task automatic test_keyboard();
        int e0;
        e0 = errors;
        cur_test = "keyboard";
        repeat (ITERS) begin
            keys = rnd(64);
            check_io_read("matrix", {8'(rnd(8)), `AQ_IO_KEYB});
        end
        finish_test(e0);
    endtask

    task automatic test_audio_ports();
        logic old_cass;
        int   e0;
        e0 = errors;
        cur_test = "audio";
        repeat (ITERS) begin
            io_write({8'h00, `AQ_IO_PRINTER}, 8'(rnd(8)), 1'b1);
            io_write({8'h00, `AQ_IO_CPM}, 8'(rnd(8)), 1'b1);
            io_write({8'h00, `AQ_IO_DAC}, 8'(rnd(8)), 1'b1);
            io_write({8'h00, `AQ_IO_CASS}, 8'(rnd(8)), 1'b1);
            if ({cassette_out, printer_out, cpm_remap} !== {m_cass, m_prn, m_cpm})
                report_error("port outputs", 64'({m_cass, m_prn, m_cpm}),
                             64'({cassette_out, printer_out, cpm_remap}));
            @(negedge clk);     // Audio register one clock behind
            if (audio_out !== exp_audio()) report_error("audio", 64'(exp_audio()), 64'(audio_out));
            old_cass    = cassette_in;
            cassette_in = 1'(rnd(1));
            printer_in  = 1'(rnd(1));
            repeat (2) @(negedge clk);
            start_cycle(1'b1, 1'b0, {8'h00, `AQ_IO_CASS}, 8'h00, 1'b0);
            if (ebus_d_out !== {7'b0, !old_cass})
                report_error("cassette early", 64'(!old_cass), 64'(ebus_d_out));
            end_cycle();
            check_io_read("cassette in", {8'h00, `AQ_IO_CASS});
            check_io_read("printer in", {8'h00, `AQ_IO_PRINTER});
        end
        finish_test(e0);
    endtask

    task automatic test_unmapped();
        logic [15:0] a;
        int          e0;
        e0 = errors;
        cur_test = "unmapped";
        repeat (ITERS) begin
            check_io_read("unmapped port", {8'(rnd(8)), 1'b0, 7'(rnd(7))});
            start_cycle(1'b0, 1'b0, 16'(rnd(16)), 8'h00, 1'b1);
            if (ebus_d_oe !== 1'b0) report_error("memory read oe", 64'(0), 64'(ebus_d_oe));
            end_cycle();
            a = {8'(rnd(8)), 4'hF, 4'(rnd(4))};
            io_write(a, 8'(rnd(8)), 1'b0);
            check_io_read("no strobe", a);
            io_write({8'h00, `AQ_IO_DAC}, 8'(rnd(8)), 1'b0);
            check_io_read("no strobe dac", {8'h00, `AQ_IO_DAC});
            if ({turbo, turbo_unlimited, cassette_out, printer_out, cpm_remap} !==
                {m_turbo, m_unl, m_cass, m_prn, m_cpm})
                report_error("outputs", 64'({m_turbo, m_unl, m_cass, m_prn, m_cpm}),
                    64'({turbo, turbo_unlimited, cassette_out, printer_out, cpm_remap}));
        end
        finish_test(e0);
    endtask

    initial begin
        lfsr                 = 32'h5e71_9b79;
        errors               = 0;
        tests_run            = 0;
        tests_clean          = 0;
        reset                = 1'b1;
        ebus_a               = '0;
        ebus_d_in            = '0;
        ebus_rd_n            = 1'b1;
        ebus_wr_n            = 1'b1;
        ebus_mreq_n          = 1'b1;
        ebus_iorq_n          = 1'b1;
        ebus_stb             = 1'b0;
        keys                 = '1;
        esp_tx_fifo_full     = 1'b0;
        esp_rx_empty         = 1'b1;
        esp_rx_data          = '0;
        esp_rx_fifo_overflow = 1'b0;
        esp_rx_framing_error = 1'b0;
        cassette_in          = 1'b0;
        printer_in           = 1'b0;
        model_reset();
        repeat (4) @(negedge clk);
        reset = 1'b0;

        test_banks();
        test_sysctrl();
        test_esp();
        test_keyboard();
        test_audio_ports();
        test_unmapped();

        $display("Summary: %0d tests run, %0d clean, %0d mismatches",
                 tests_run, tests_clean, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: aq_bus.f
+incdir+.
aq_pkg.sv
aq_bank_decode.sv
aq_io_regs.sv
aq_read_mux.sv
aq_bus.sv
tb_aq_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the bus glue testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_aq_bus -f aq_bus.f -Mdir obj_dir -o tb_aq_bus
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_aq_bus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "tests failed" "$LOG"
rc=$?
if [ $rc -eq 0 ]; then
    echo "Result: FAIL"
    exit 1
elif [ $rc -ne 1 ]; then
    echo "Could not search $LOG"
    exit 1
fi
echo "Result: PASS"
exit 0
